/* sim.f */
+incdir+include
rtl/modExpArithPkg.sv
rtl/modExpCtrlPkg.sv
rtl/operandLoad.sv
rtl/modMul.sv
rtl/expSequencer.sv
rtl/resultBuffer.sv
rtl/modExpTop.sv
verification/modExpTb.sv

/* include/modExpModel.svh */
`ifndef MODEXPMODEL_SVH
`define MODEXPMODEL_SVH

typedef logic [2*modExpArithPkg::kOpWidth-1:0] modelWide_t; // untruncated product

// (a * b) mod n on double-width intermediates
function automatic modExpArithPkg::opVec_t modelModMul(
	input modExpArithPkg::opVec_t a,
	input modExpArithPkg::opVec_t b,
	input modExpArithPkg::opVec_t n
);
	modelWide_t prod;
	modelWide_t rem;
	prod = modelWide_t'(a) * modelWide_t'(b);
	rem = prod % modelWide_t'(n);
	return rem[modExpArithPkg::kOpWidth-1:0];
endfunction

// square-and-multiply over every exponent bit
function automatic modExpArithPkg::opVec_t modelModExp(
	input modExpArithPkg::opVec_t m,
	input modExpArithPkg::opVec_t e,
	input modExpArithPkg::opVec_t n
);
	modExpArithPkg::opVec_t r;
	modExpArithPkg::opVec_t b;
	r = modExpArithPkg::opVec_t'(1); // n >= 2 keeps this reduced
	b = m;
	for (int i = 0; i < modExpArithPkg::kOpWidth; i++) begin
		if (e[i]) begin
			r = modelModMul(r, b, n);
		end
		b = modelModMul(b, b, n);
	end
	return r;
endfunction

// word seen on rData after idx rotations
function automatic modExpArithPkg::word_t modelWord(
	input modExpArithPkg::opVec_t v,
	input int idx
);
	int pos;
	pos = (idx % modExpArithPkg::kNumWords) * modExpArithPkg::kWordWidth;
	return v[pos +: modExpArithPkg::kWordWidth];
endfunction

`endif

/* verification/modExpTb.sv */
module modExpTb;

	`include "modExpModel.svh"

	localparam int kNumTests = 48; // 3 + 3 + 2 directed, 40 random
	localparam int kCyclesPerTest = 33000; // 127 bits times two multiplies of up to 128 cycles
	localparam int kCycleLimit = (kNumTests + 12) * kCyclesPerTest; // a dozen tests of slack
	localparam int kPokeCycle = 1000; // well past the first squaring

	logic iClk;
	logic M_reset0;
	logic start;
	logic wrM;
	logic wrE;
	logic wrN;
	logic rdR;
	modExpArithPkg::word_t m;
	modExpArithPkg::word_t e;
	modExpArithPkg::word_t n;
	modExpArithPkg::word_t rData;
	logic done;
	logic busy;

	int valueErrs; // wrong result words
	int protocolErrs; // done/busy timing
	int cycleCount;
	int testNum;

	modExpTop u_modExpTop (
		.iClk(iClk),
		.M_reset0(M_reset0),
		.start(start),
		.wrM(wrM),
		.wrE(wrE),
		.wrN(wrN),
		.rdR(rdR),
		.m(m),
		.e(e),
		.n(n),
		.rData(rData),
		.done(done),
		.busy(busy)
	);

	initial begin
		iClk = 1'b0;
		forever #2 iClk = ~iClk; // period 4
	end

	always @(posedge iClk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= kCycleLimit) begin
			$display("timeout: run still going after %0d cycles", cycleCount);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// inputs change 1 unit after the edge once outputs have settled
	task automatic nextCycle;
		@(posedge iClk);
		#1;
	endtask

	function automatic modExpArithPkg::opVec_t randVec();
		modExpArithPkg::opVec_t v;
		for (int i = 0; i < modExpArithPkg::kOpWidth / 32; i++) begin
			v[i*32 +: 32] = $urandom;
		end
		return v;
	endfunction

	// narrow keeps N below 2^64, so the high words are zero
	function automatic modExpArithPkg::opVec_t randModulus(input bit narrow);
		modExpArithPkg::opVec_t v;
		v = randVec();
		if (narrow) begin
			v[modExpArithPkg::kOpWidth-1:modExpArithPkg::kWordWidth] = '0;
		end else begin
			v[modExpArithPkg::kOpWidth-1] = 1'b1; // full width
		end
		if (v < 2) begin
			v = v + 2;
		end
		return v;
	endfunction

	task automatic loadOperands(
		input modExpArithPkg::opVec_t mVal,
		input modExpArithPkg::opVec_t eVal,
		input modExpArithPkg::opVec_t nVal
	);
		for (int w = 0; w < modExpArithPkg::kNumWords; w++) begin // low word first
			m = mVal[w*modExpArithPkg::kWordWidth +: modExpArithPkg::kWordWidth];
			wrM = 1'b1;
			nextCycle;
			wrM = 1'b0;
			e = eVal[w*modExpArithPkg::kWordWidth +: modExpArithPkg::kWordWidth];
			wrE = 1'b1;
			nextCycle;
			wrE = 1'b0;
			n = nVal[w*modExpArithPkg::kWordWidth +: modExpArithPkg::kWordWidth];
			wrN = 1'b1;
			nextCycle;
			wrN = 1'b0;
		end
	endtask

	task automatic runTest(
		input modExpArithPkg::opVec_t mVal,
		input modExpArithPkg::opVec_t eVal,
		input modExpArithPkg::opVec_t nVal,
		input bit poke // second start while busy
	);
		modExpArithPkg::opVec_t expR;
		modExpArithPkg::word_t expWord;
		int waitCycles;
		testNum++;
		expR = modelModExp(mVal, eVal, nVal);
		loadOperands(mVal, eVal, nVal);
		start = 1'b1;
		nextCycle;
		start = 1'b0;
		waitCycles = 0;
		while (!done) begin
			assert (busy) else begin
				$display("test %0d: busy low before done", testNum);
				protocolErrs++;
			end
			if (poke && waitCycles == kPokeCycle) begin
				start = 1'b1; // must be ignored
			end
			nextCycle;
			start = 1'b0;
			waitCycles++;
		end
		assert (busy) else begin
			$display("test %0d: busy low in the done cycle", testNum);
			protocolErrs++;
		end
		nextCycle;
		assert (!done) else begin
			$display("test %0d: done high for more than one cycle", testNum);
			protocolErrs++;
		end
		assert (!busy) else begin
			$display("test %0d: busy still high after done", testNum);
			protocolErrs++;
		end
		for (int idx = 0; idx <= modExpArithPkg::kNumWords + 1; idx++) begin
			expWord = modelWord(expR, idx); // low, high, low, high
			assert (rData === expWord) else begin
				$display("Fail rData test %0d read %0d: got %h expected %h",
					testNum, idx, rData, expWord);
				valueErrs++;
			end
			if (idx <= modExpArithPkg::kNumWords) begin
				rdR = 1'b1;
				nextCycle;
				rdR = 1'b0;
			end
		end
	endtask

	initial begin
		modExpArithPkg::opVec_t nVal;
		modExpArithPkg::opVec_t mVal;
		void'($urandom(32'h64d27ee2)); // only seeding call
		valueErrs = 0;
		protocolErrs = 0;
		cycleCount = 0;
		testNum = 0;
		M_reset0 = 1'b1;
		start = 1'b0;
		wrM = 1'b0;
		wrE = 1'b0;
		wrN = 1'b0;
		rdR = 1'b0;
		m = '0;
		e = '0;
		n = '0;
		repeat (3) @(posedge iClk);
		#1;
		M_reset0 = 1'b0;
		assert (!done && !busy) else begin
			$display("done or busy high after reset");
			protocolErrs++;
		end
		for (int i = 0; i < 3; i++) begin // E = 0 gives one
			nVal = randModulus(i == 2);
			mVal = randVec() % nVal;
			runTest(mVal, '0, nVal, 1'b0);
		end
		for (int i = 0; i < 3; i++) begin // E = 1 gives M
			nVal = randModulus(i == 1);
			mVal = randVec() % nVal;
			runTest(mVal, modExpArithPkg::opVec_t'(1), nVal, 1'b0);
		end
		for (int i = 0; i < 2; i++) begin // zero base
			nVal = randModulus(i == 1);
			runTest('0, randVec() | modExpArithPkg::opVec_t'(1), nVal, 1'b0);
		end
		for (int i = 0; i < 40; i++) begin
			nVal = randModulus(i % 4 == 3); // every 4th narrow
			mVal = randVec() % nVal;
			runTest(mVal, randVec(), nVal, i % 5 == 2);
		end
		$display("errors: %0d wrong values, %0d protocol", valueErrs, protocolErrs);
		if (valueErrs + protocolErrs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* rtl/modExpTop.sv */
module modExpTop (
	input  logic iClk,
	input  logic M_reset0,
	input  logic start,
	input  logic wrM,
	input  logic wrE,
	input  logic wrN,
	input  logic rdR,
	input  modExpArithPkg::word_t m,
	input  modExpArithPkg::word_t e,
	input  modExpArithPkg::word_t n,
	output modExpArithPkg::word_t rData,
	output logic done,
	output logic busy
);

	modExpArithPkg::opVec_t opM;
	modExpArithPkg::opVec_t opE;
	modExpArithPkg::opVec_t opN;
	modExpArithPkg::opVec_t resultVal; // R back to the sequencer
	modExpCtrlPkg::mulReq_t mulReq;
	modExpCtrlPkg::mulRsp_t mulRsp;
	logic setOne;
	logic loadProduct;

	operandLoad u_operandLoad (
		.iClk(iClk),
		.M_reset0(M_reset0),
		.wrM(wrM),
		.wrE(wrE),
		.wrN(wrN),
		.m(m),
		.e(e),
		.n(n),
		.opM(opM),
		.opE(opE),
		.opN(opN)
	);

	expSequencer u_expSequencer (
		.iClk(iClk),
		.M_reset0(M_reset0),
		.start(start),
		.opM(opM),
		.opE(opE),
		.resultVal(resultVal),
		.mulRsp(mulRsp),
		.mulReq(mulReq),
		.setOne(setOne),
		.loadProduct(loadProduct),
		.done(done),
		.busy(busy)
	);

	modMul u_modMul (
		.iClk(iClk),
		.M_reset0(M_reset0),
		.req(mulReq),
		.modulus(opN),
		.rsp(mulRsp)
	);

	resultBuffer u_resultBuffer (
		.iClk(iClk),
		.M_reset0(M_reset0),
		.setOne(setOne),
		.loadProduct(loadProduct),
		.rdR(rdR),
		.product(mulRsp.product), // taken on a result multiply
		.resultVal(resultVal),
		.rData(rData)
	);

endmodule

/* rtl/resultBuffer.sv */
module resultBuffer (
	input  logic iClk,
	input  logic M_reset0,
	input  logic setOne,
	input  logic loadProduct,
	input  logic rdR, // rotate one word for readout
	input  modExpArithPkg::opVec_t product,
	output modExpArithPkg::opVec_t resultVal, // R
	output modExpArithPkg::word_t rData // low word of R
);

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			resultVal <= '0;
		end else if (setOne) begin
			resultVal <= modExpArithPkg::opVec_t'(1); // exponent loop starts at one
		end else if (loadProduct) begin
			resultVal <= product;
		end else if (rdR) begin
			resultVal <= {resultVal[modExpArithPkg::kWordWidth-1:0],
				resultVal[modExpArithPkg::kOpWidth-1:modExpArithPkg::kWordWidth]};
		end
	end

	assign rData = resultVal[modExpArithPkg::kWordWidth-1:0];

	// readout only outside a computation
	assert property (@(posedge iClk) disable iff (M_reset0)
		!((setOne || loadProduct) && rdR))
		else $error("resultBuffer: rdR during a result update");

endmodule

/* rtl/expSequencer.sv */
module expSequencer (
	input  logic iClk,
	input  logic M_reset0,
	input  logic start,
	input  modExpArithPkg::opVec_t opM,
	input  modExpArithPkg::opVec_t opE,
	input  modExpArithPkg::opVec_t resultVal, // current R
	input  modExpCtrlPkg::mulRsp_t mulRsp,
	output modExpCtrlPkg::mulReq_t mulReq,
	output logic setOne, // R = 1
	output logic loadProduct, // R = product
	output logic done,
	output logic busy
);

	modExpCtrlPkg::seqState_t state;
	modExpCtrlPkg::seqState_t stateNext;
	modExpArithPkg::opVec_t expRem; // exponent bits still to scan
	modExpArithPkg::opVec_t base; // M^(2^i) mod N
	logic mulStart; // registered multiply strobe
	logic mulStartNext;
	logic expRestZero; // nothing above the current bit
	logic mulDone;

	assign expRestZero = (expRem[modExpArithPkg::kOpWidth-1:1] == '0);
	assign mulDone = mulRsp.done;

	always_comb begin
		stateNext = state;
		mulStartNext = 1'b0;
		case (state)
			modExpCtrlPkg::stIdle: begin
				if (start) begin
					stateNext = modExpCtrlPkg::stScan;
				end
			end
			modExpCtrlPkg::stScan: begin
				if (expRem == '0) begin
					stateNext = modExpCtrlPkg::stFinish; // early exit
				end else if (expRem[0]) begin
					stateNext = modExpCtrlPkg::stMulResult;
					mulStartNext = 1'b1;
				end else begin
					stateNext = modExpCtrlPkg::stMulBase; // higher bits remain
					mulStartNext = 1'b1;
				end
			end
			modExpCtrlPkg::stMulResult: begin
				if (mulDone && expRestZero) begin
					stateNext = modExpCtrlPkg::stFinish; // last bit, no squaring
				end else if (mulDone) begin
					stateNext = modExpCtrlPkg::stMulBase;
					mulStartNext = 1'b1;
				end
			end
			modExpCtrlPkg::stMulBase: begin
				if (mulDone) begin
					stateNext = modExpCtrlPkg::stScan;
				end
			end
			modExpCtrlPkg::stFinish: begin
				stateNext = modExpCtrlPkg::stIdle;
			end
			default: begin
				stateNext = modExpCtrlPkg::stIdle;
			end
		endcase
	end

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			state <= modExpCtrlPkg::stIdle;
			mulStart <= 1'b0;
			expRem <= '0;
		end else begin
			state <= stateNext;
			mulStart <= mulStartNext; // high in first cycle of a mul state
			if (setOne) begin
				expRem <= opE;
			end else if (state == modExpCtrlPkg::stMulBase && mulDone) begin
				expRem <= expRem >> 1; // bit consumed
			end
		end
	end

	always_ff @(posedge iClk) begin
		if (setOne) begin
			base <= opM;
		end else if (state == modExpCtrlPkg::stMulBase && mulDone) begin
			base <= mulRsp.product; // squared base
		end
	end

	assign setOne = (state == modExpCtrlPkg::stIdle) && start; // start ignored when busy
	assign loadProduct = (state == modExpCtrlPkg::stMulResult) && mulDone;
	assign done = (state == modExpCtrlPkg::stFinish);
	assign busy = (state != modExpCtrlPkg::stIdle);

	assign mulReq.start = mulStart;
	assign mulReq.multiplicand = (state == modExpCtrlPkg::stMulResult) ? resultVal : base;
	assign mulReq.multiplier = base; // R * base or base * base

	// a multiply completes only while one is outstanding
	assert property (@(posedge iClk) disable iff (M_reset0)
		mulDone |-> state inside {modExpCtrlPkg::stMulResult, modExpCtrlPkg::stMulBase})
		else $error("expSequencer: multiply done in state %0d", state);

endmodule

/* rtl/modMul.sv */
module modMul (
	input  logic iClk,
	input  logic M_reset0,
	input  modExpCtrlPkg::mulReq_t req,
	input  modExpArithPkg::opVec_t modulus, // N, held stable while busy
	output modExpCtrlPkg::mulRsp_t rsp
);

	logic busy; // multiply in progress
	logic doneReg; // completion pulse
	modExpArithPkg::opVec_t mult; // multiplier bits not yet used
	modExpArithPkg::opVec_t addend; // multiplicand * 2^i mod N
	modExpArithPkg::opVec_t acc; // partial product mod N
	modExpArithPkg::opVec_t multNext;
	modExpArithPkg::opVec_t addendNext;
	modExpArithPkg::opVec_t accNext;
	modExpArithPkg::wideVec_t sum; // acc + addend, below 2N
	modExpArithPkg::wideVec_t dbl; // 2 * addend, below 2N

	// one subtraction is enough for inputs below 2N
	function automatic modExpArithPkg::opVec_t condSub(
		input modExpArithPkg::wideVec_t x,
		input modExpArithPkg::opVec_t mod
	);
		modExpArithPkg::wideVec_t modWide;
		modExpArithPkg::wideVec_t diff;
		modWide = {1'b0, mod};
		diff = x - modWide;
		if (x >= modWide) begin
			return diff[modExpArithPkg::kOpWidth-1:0];
		end
		return x[modExpArithPkg::kOpWidth-1:0];
	endfunction

	always_comb begin
		sum = {1'b0, acc} + {1'b0, addend}; // full-width add
		dbl = {addend, 1'b0};
		accNext = mult[0] ? condSub(sum, modulus) : acc; // add only on a set bit
		addendNext = condSub(dbl, modulus);
		multNext = mult >> 1;
	end

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			busy <= 1'b0;
			doneReg <= 1'b0;
		end else begin
			doneReg <= 1'b0; // single-cycle pulse
			if (req.start) begin
				busy <= 1'b1;
			end else if (busy && multNext == '0) begin
				busy <= 1'b0; // no set bits left
				doneReg <= 1'b1;
			end
		end
	end

	always_ff @(posedge iClk) begin
		if (req.start) begin
			mult <= req.multiplier;
			addend <= req.multiplicand;
			acc <= '0;
		end else if (busy) begin
			mult <= multNext; // one bit per cycle
			addend <= addendNext;
			acc <= accNext;
		end
	end

	assign rsp.done = doneReg;
	assign rsp.product = acc; // final value in the done cycle

	assert property (@(posedge iClk) disable iff (M_reset0) req.start |-> !busy)
		else $error("modMul: start while busy");

	// reduction has held across every step of the multiply
	assert property (@(posedge iClk) disable iff (M_reset0)
		rsp.done |-> rsp.product < modulus)
		else $error("modMul: product %h not below modulus %h", rsp.product, modulus);

endmodule

/* rtl/operandLoad.sv */
module operandLoad (
	input  logic iClk,
	input  logic M_reset0,
	input  logic wrM, // shift strobe for M
	input  logic wrE, // shift strobe for E
	input  logic wrN, // shift strobe for N
	input  modExpArithPkg::word_t m,
	input  modExpArithPkg::word_t e,
	input  modExpArithPkg::word_t n,
	output modExpArithPkg::opVec_t opM, // base operand
	output modExpArithPkg::opVec_t opE, // exponent
	output modExpArithPkg::opVec_t opN // modulus
);

	// new word on top, first word ends up lowest
	function automatic modExpArithPkg::opVec_t shiftIn(
		input modExpArithPkg::opVec_t cur,
		input modExpArithPkg::word_t word
	);
		return {word, cur[modExpArithPkg::kOpWidth-1:modExpArithPkg::kWordWidth]};
	endfunction

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			opM <= '0;
		end else if (wrM) begin
			opM <= shiftIn(opM, m); // right shift by one word
		end
	end

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			opE <= '0;
		end else if (wrE) begin
			opE <= shiftIn(opE, e);
		end
	end

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			opN <= '0;
		end else if (wrN) begin
			opN <= shiftIn(opN, n); // also feeds the multiplier
		end
	end

	// the bus carries a single word, so one register per cycle
	assert property (@(posedge iClk) disable iff (M_reset0)
		$onehot0({wrM, wrE, wrN}))
		else $error("operandLoad: two write strobes in one cycle");

endmodule

/* rtl/modExpCtrlPkg.sv */
package modExpCtrlPkg;

	// exponent scan states
	typedef enum logic [2:0] {
		stIdle, // waiting for start
		stScan, // look at low exponent bit
		stMulResult, // R = R * base running
		stMulBase, // base = base * base running
		stFinish // done pulse
	} seqState_t;

	// sequencer to multiplier
	typedef struct packed {
		logic start; // one-cycle strobe, multiplier idle
		modExpArithPkg::opVec_t multiplicand; // becomes the addend
		modExpArithPkg::opVec_t multiplier; // scanned lsb first
	} mulReq_t;

	// multiplier to sequencer
	typedef struct packed {
		logic done; // one-cycle pulse
		modExpArithPkg::opVec_t product; // valid while done is high
	} mulRsp_t;

endpackage

/* rtl/modExpArithPkg.sv */
package modExpArithPkg;

	localparam int kOpWidth = 128; // bits per operand and result
	localparam int kWordWidth = 64; // bus word for load and readout
	localparam int kNumWords = kOpWidth / kWordWidth; // words per operand

	typedef logic [kOpWidth-1:0] opVec_t; // M, E, N, R or a product
	typedef logic [kOpWidth:0] wideVec_t; // guard bit for sum and doubled addend
	typedef logic [kWordWidth-1:0] word_t; // one bus word

endpackage
